//--- Makefile
SIM  := obj_dir/Vahb_read_cache_tb
SRCS := $(shell grep -v '^+' verilog.f) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module ahb_read_cache_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- bench/ahb_memory_model.sv
`timescale 1ns/1ns

module ahb_memory_model (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  ahb_cache_pkg::ahb_req_t  dn_req,
    output ahb_cache_pkg::ahb_rsp_t  dn_rsp
);

    logic        busy;
    logic [31:0] addr;
    logic [1:0]  waits;
    logic        active;

    // every address bit shows up in the word
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] word_addr;
        logic [31:0] rotated;
        word_addr = a >> 2;
        rotated   = {a[15:0], a[31:16]};
        return (word_addr ^ 32'h5A5A_0000) + rotated;
    endfunction

    assign active = dn_req.htrans == ahb_cache_pkg::NONSEQ
                 || dn_req.htrans == ahb_cache_pkg::SEQ;

    // data phase follows the accepted address with 0 to 3 wait states
    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            addr  <= 32'h0;
            waits <= 2'd0;
        end else if (dn_rsp.hready) begin
            if (active) begin
                busy  <= 1'b1;
                addr  <= dn_req.haddr;
                waits <= 2'($urandom_range(3, 0));
            end else begin
                busy <= 1'b0;
            end
        end else begin
            waits <= waits - 2'd1;
        end
    end

    // idle slave keeps hready high
    assign dn_rsp.hready = !rst_n || !busy || (waits == 2'd0);
    assign dn_rsp.hrdata = (rst_n && busy && waits == 2'd0) ? word_at(addr) : 32'h0;

endmodule

//--- bench/ahb_read_cache_assertions.sv
`timescale 1ns/1ns

module ahb_read_cache_assertions (
    input logic                     upstream_intf,
    input logic                     rst_n,
    input ahb_cache_pkg::ahb_req_t  up_req,
    input ahb_cache_pkg::ahb_req_t  dn_req,
    input ahb_cache_pkg::ahb_rsp_t  dn_rsp
);

    // a burst only continues from an active transfer
    no_seq_after_idle: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        dn_req.htrans == ahb_cache_pkg::IDLE |=> dn_req.htrans != ahb_cache_pkg::SEQ)
        else $error("downstream SEQ directly after IDLE");

    // extended address phase holds its address
    haddr_held: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        (dn_req.htrans != ahb_cache_pkg::IDLE && !dn_rsp.hready) |=> $stable(dn_req.haddr))
        else $error("downstream haddr changed during a wait state");

    up_read_only: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        up_req.hwrite == 1'b0)
        else $error("upstream write seen");

    nonseq_is_wrap4: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        dn_req.htrans == ahb_cache_pkg::NONSEQ |-> dn_req.hburst == ahb_cache_pkg::WRAP4)
        else $error("downstream NONSEQ without WRAP4");

endmodule

bind ahb_read_cache ahb_read_cache_assertions u_assertions (.*);

//--- bench/ahb_read_cache_tb.sv
`timescale 1ns/1ns
`include "ahb_cache_config.svh"

module ahb_read_cache_tb;

    localparam int READ_TOTAL  = 307;
    localparam int CYCLE_LIMIT = `LINE_COUNT + 40 * READ_TOTAL + 5;

    logic                    upstream_intf;
    logic                    rst_n;
    ahb_cache_pkg::ahb_req_t up_req;
    ahb_cache_pkg::ahb_rsp_t up_rsp;
    ahb_cache_pkg::ahb_req_t dn_req;
    ahb_cache_pkg::ahb_rsp_t dn_rsp;

    // accepted upstream reads waiting for their data phase
    logic [31:0] issued [$];
    logic        phase_open;
    int          stall_count;

    // expected misses as one tag per index
    logic [`TAG_BITS-1:0] model_tag [`LINE_COUNT];
    logic                 model_valid [`LINE_COUNT];
    logic [31:0]          burst_expect [$];
    int                   miss_count;

    logic [31:0] burst_start;
    int          beat;
    int          nonseq_count;
    int          dn_addr_count;
    int          cycles;
    bit          fail_printed;
    bit          run_passed;

    ahb_read_cache u_dut (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .up_req        (up_req),
        .up_rsp        (up_rsp),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

    ahb_memory_model u_memory (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp)
    );

    initial upstream_intf = 1'b0;
    always #4 upstream_intf = ~upstream_intf;

    // word address xor a constant plus the address rotated by half
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        logic [31:0] rotated;
        word_addr = {2'b00, addr[31:2]};
        rotated   = {addr[15:0], addr[31:16]};
        return (word_addr ^ 32'h5A5A_0000) + rotated;
    endfunction

    function automatic void predict_miss(input logic [31:0] addr);
        logic [`INDEX_BITS-1:0] idx;
        logic [`TAG_BITS-1:0]   tag;
        idx = addr[`OFFSET_BITS + 2 +: `INDEX_BITS];
        tag = addr[31 -: `TAG_BITS];
        if (!model_valid[idx] || model_tag[idx] != tag) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            miss_count++;
            burst_expect.push_back({addr[31:2], 2'b00});
        end
    endfunction

    task automatic stop_on_error();
        fail_printed = 1'b1;
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // address phase held until an edge with hready high
    task automatic drive_read(input logic [31:0] addr);
        up_req.haddr  = addr;
        up_req.htrans = ahb_cache_pkg::NONSEQ;
        up_req.hburst = ahb_cache_pkg::SINGLE;
        @(posedge upstream_intf);
        while (!up_rsp.hready) begin
            @(posedge upstream_intf);
        end
        @(negedge upstream_intf);
    endtask

    task automatic drive_idle(input int n);
        up_req.htrans = ahb_cache_pkg::IDLE;
        repeat (n) @(negedge upstream_intf);
    endtask

    task automatic finish_reads();
        drive_idle(1);
        while (issued.size() != 0) begin
            @(negedge upstream_intf);
        end
    endtask

    // data phase checked before the next address is taken
    always @(posedge upstream_intf) begin : up_monitor
        logic [31:0] addr;
        if (rst_n) begin
            if (phase_open && !up_rsp.hready) begin
                stall_count++;
            end
            if (phase_open && up_rsp.hready && issued.size() == 0) begin
                $display("upstream data phase ended with no read on record");
                stop_on_error();
            end else if (phase_open && up_rsp.hready) begin
                addr = issued.pop_front();
                check_value("up_rsp.hrdata", up_rsp.hrdata, mem_word(addr));
            end
            if (up_rsp.hready) begin
                phase_open = !up_req.hwrite
                          && (up_req.htrans == ahb_cache_pkg::NONSEQ
                           || up_req.htrans == ahb_cache_pkg::SEQ);
                if (phase_open) begin
                    issued.push_back(up_req.haddr);
                    predict_miss(up_req.haddr);
                end
            end
        end else begin
            phase_open = 1'b0;
        end
    end

    // downstream bursts start at the critical word and wrap in the line
    always @(posedge upstream_intf) begin : dn_monitor
        logic [1:0] word_off;
        if (rst_n && dn_rsp.hready) begin
            check_value("dn_req.hwrite", 32'(dn_req.hwrite), 32'h0);
            check_value("dn_req.hwdata", dn_req.hwdata, 32'h0);
            if (dn_req.htrans == ahb_cache_pkg::NONSEQ && burst_expect.size() == 0) begin
                $display("downstream burst started with no miss outstanding");
                stop_on_error();
            end else if (dn_req.htrans == ahb_cache_pkg::NONSEQ) begin
                check_value("dn_req.haddr", dn_req.haddr, burst_expect.pop_front());
                burst_start = dn_req.haddr;
                beat        = 1;
                nonseq_count++;
                dn_addr_count++;
            end else if (dn_req.htrans == ahb_cache_pkg::SEQ && beat >= 4) begin
                $display("downstream burst longer than four beats");
                stop_on_error();
            end else if (dn_req.htrans == ahb_cache_pkg::SEQ) begin
                word_off = burst_start[3:2] + beat[1:0];
                check_value("dn_req.haddr", dn_req.haddr,
                            {burst_start[31:4], word_off, 2'b00});
                beat++;
                dn_addr_count++;
            end
        end
    end

    always @(posedge upstream_intf) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            stop_on_error();
        end
    end

    initial begin : stimulus
        int          sweep_cycles;
        int          stalls_before;
        logic [31:0] base;
        logic [31:0] addr;

        void'($urandom(76));
        rst_n         = 1'b0;
        up_req        = '0;
        phase_open    = 1'b0;
        stall_count   = 0;
        miss_count    = 0;
        nonseq_count  = 0;
        dn_addr_count = 0;
        beat          = 0;
        burst_start   = 32'h0;
        cycles        = 0;
        for (int i = 0; i < `LINE_COUNT; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (5) @(posedge upstream_intf);
        @(negedge upstream_intf);
        rst_n = 1'b1;

        // sweep holds hready low and downstream stays quiet
        sweep_cycles = 0;
        @(posedge upstream_intf);
        while (!up_rsp.hready) begin
            sweep_cycles++;
            check_value("dn_req.htrans", 32'(dn_req.htrans), 32'(ahb_cache_pkg::IDLE));
            @(posedge upstream_intf);
        end
        check_value("sweep cycles", sweep_cycles, `LINE_COUNT);
        @(negedge upstream_intf);
        check_value("dn_req.htrans", 32'(dn_req.htrans), 32'(ahb_cache_pkg::IDLE));

        // cold read of word 2 in its line
        base = 32'h0000_1048;
        drive_read(base);
        finish_reads();
        check_value("nonseq count", nonseq_count, 1);
        check_value("dn address count", dn_addr_count, 4);

        // rest of the line hits with no stall
        stalls_before = stall_count;
        drive_read(base ^ 32'h4);
        drive_read(base ^ 32'h8);
        drive_read(base ^ 32'hC);
        drive_read(base);
        finish_reads();
        check_value("nonseq count", nonseq_count, 1);
        check_value("stall cycles", stall_count, stalls_before);

        // conflicting tag at the same index
        drive_read(base + `CACHE_BYTES);
        finish_reads();
        check_value("nonseq count", nonseq_count, 2);
        drive_read(base);
        finish_reads();
        check_value("nonseq count", nonseq_count, 3);

        // 8 lines under two tags with mixed gaps
        for (int i = 0; i < 300; i++) begin
            addr = 32'h0004_0000 | ($urandom & 32'h0000_207C);
            drive_read(addr);
            if ($urandom_range(3, 0) == 0) begin
                drive_idle(1 + $urandom_range(2, 0));
            end
        end
        finish_reads();
        check_value("nonseq count", nonseq_count, miss_count);
        check_value("dn address count", dn_addr_count, 4 * nonseq_count);
        check_value("bursts outstanding", burst_expect.size(), 0);

        run_passed = 1'b1;
        $display("all tests passed");
        $finish;
    end

    final begin
        if (!run_passed && !fail_printed) begin
            $display("tests failed");
        end
    end

endmodule

//--- hw/ahb_cache_config.svh
`ifndef AHB_CACHE_CONFIG_SVH
`define AHB_CACHE_CONFIG_SVH

// capacity in bytes and line geometry
`define CACHE_BYTES 8192
`define LINE_BITS 128
`define WORDS_PER_LINE (`LINE_BITS / 32)

// derived line count, must stay a power of two
`define LINE_COUNT (`CACHE_BYTES * 8 / `LINE_BITS)

// address split widths
`define INDEX_BITS 9
`define OFFSET_BITS 2

// two low address bits select the byte within a word
`define TAG_BITS (32 - `INDEX_BITS - `OFFSET_BITS - 2)

`endif

//--- hw/ahb_cache_pkg.sv
package ahb_cache_pkg;

    // AHB transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // AHB burst type
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_t;

    // master to slave signals of one bus
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hburst_t     hburst;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    // slave to master signals
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
    } ahb_rsp_t;

    // read held in its upstream data phase
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } lookup_t;

    // downstream line fill
    typedef enum logic [1:0] {
        IDLE_S  = 2'b00,
        ADDR_S  = 2'b01,
        BEATS_S = 2'b10,
        DONE_S  = 2'b11
    } fill_state_t;

endpackage

//--- hw/ahb_read_cache.sv
`timescale 1ns/1ns
`include "ahb_cache_config.svh"

module ahb_read_cache (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  ahb_cache_pkg::ahb_req_t  up_req,
    output ahb_cache_pkg::ahb_rsp_t  up_rsp,
    output ahb_cache_pkg::ahb_req_t  dn_req,
    input  ahb_cache_pkg::ahb_rsp_t  dn_rsp
);

    ahb_cache_pkg::lookup_t lookup;
    logic                   hit;
    logic [`LINE_BITS-1:0]  fill_line;
    logic                   fill_done;

    // upstream hready closes the data phase of the held read
    ahb_slave_capture u_capture (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .up_req        (up_req),
        .ready         (up_rsp.hready),
        .lookup        (lookup)
    );

    cache_tag_store u_tag_store (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup        (lookup),
        .fill_line     (fill_line),
        .fill_done     (fill_done),
        .hit           (hit),
        .up_rsp        (up_rsp)
    );

    line_fill_master u_fill (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup        (lookup),
        .hit           (hit),
        .dn_rsp        (dn_rsp),
        .dn_req        (dn_req),
        .fill_line     (fill_line),
        .fill_done     (fill_done)
    );

endmodule

//--- hw/ahb_slave_capture.sv
`timescale 1ns/1ns

module ahb_slave_capture (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  ahb_cache_pkg::ahb_req_t  up_req,
    input  logic                     ready,
    output ahb_cache_pkg::lookup_t   lookup
);

    logic        accept;
    logic        held_valid;
    logic [31:0] held_addr;

    // only NONSEQ and SEQ reads count, IDLE and BUSY fall through
    assign accept = ready
                 && !up_req.hwrite
                 && (up_req.htrans == ahb_cache_pkg::NONSEQ
                  || up_req.htrans == ahb_cache_pkg::SEQ);

    // data phase closes on ready, a new address may open the next one
    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (ready) begin
            held_valid <= accept;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            held_addr <= up_req.haddr;
        end
    end

    // stays put while the stalled read waits for its line
    assign lookup.valid = held_valid;
    assign lookup.addr  = held_addr;

endmodule

//--- hw/cache_tag_store.sv
`timescale 1ns/1ns
`include "ahb_cache_config.svh"

module cache_tag_store (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  ahb_cache_pkg::lookup_t   lookup,
    input  logic [`LINE_BITS-1:0]    fill_line,
    input  logic                     fill_done,
    output logic                     hit,
    output ahb_cache_pkg::ahb_rsp_t  up_rsp
);

    logic [`TAG_BITS-1:0]             tag_mem [`LINE_COUNT];
    logic [`WORDS_PER_LINE-1:0][31:0] line_mem [`LINE_COUNT];
    logic [`LINE_COUNT-1:0]           valid_mem;

    logic [`TAG_BITS-1:0]    tag;
    logic [`INDEX_BITS-1:0]  index;
    logic [`OFFSET_BITS-1:0] offset;

    logic                    sweeping;
    logic [`INDEX_BITS-1:0]  sweep_idx;

    // tag | index | word | byte
    assign tag    = lookup.addr[31 -: `TAG_BITS];
    assign index  = lookup.addr[`OFFSET_BITS + 2 +: `INDEX_BITS];
    assign offset = lookup.addr[2 +: `OFFSET_BITS];

    // walk all indices once after reset
    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == `INDEX_BITS'(`LINE_COUNT - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (sweeping) begin
            valid_mem[sweep_idx] <= 1'b0;
        end else if (fill_done) begin
            valid_mem[index] <= 1'b1;
        end
    end

    // refill lands at the index of the stalled read
    always_ff @(posedge upstream_intf) begin
        if (fill_done) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= fill_line;
        end
    end

    assign hit = lookup.valid && valid_mem[index] && (tag_mem[index] == tag);

    // word mux straight off the stored line
    assign up_rsp.hrdata = line_mem[index][offset];

    // a pending miss stalls the data phase until the refill hits
    assign up_rsp.hready = !sweeping && (!lookup.valid || hit);

endmodule

//--- hw/line_fill_master.sv
`timescale 1ns/1ns
`include "ahb_cache_config.svh"

module line_fill_master (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  ahb_cache_pkg::lookup_t   lookup,
    input  logic                     hit,
    input  ahb_cache_pkg::ahb_rsp_t  dn_rsp,
    output ahb_cache_pkg::ahb_req_t  dn_req,
    output logic [`LINE_BITS-1:0]    fill_line,
    output logic                     fill_done
);

    ahb_cache_pkg::fill_state_t state;

    logic [31:`OFFSET_BITS + 2]       line_base;
    logic [`OFFSET_BITS-1:0]          start_off;
    logic [`OFFSET_BITS:0]            addr_cnt;
    logic [`OFFSET_BITS-1:0]          data_cnt;
    logic [`OFFSET_BITS-1:0]          addr_off;
    logic [`OFFSET_BITS-1:0]          data_off;
    logic [`WORDS_PER_LINE-1:0][31:0] line_buf;

    logic miss;
    logic all_issued;
    logic last_beat;

    assign miss = lookup.valid && !hit;

    // offsets wrap inside the line, critical word first
    assign addr_off = start_off + addr_cnt[`OFFSET_BITS-1:0];
    assign data_off = start_off + data_cnt;

    // top bit of addr_cnt sets once all four addresses went out
    assign all_issued = addr_cnt[`OFFSET_BITS];
    assign last_beat  = &data_cnt;

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            state    <= ahb_cache_pkg::IDLE_S;
            addr_cnt <= '0;
            data_cnt <= '0;
        end else begin
            case (state)
                ahb_cache_pkg::IDLE_S: begin
                    if (miss) begin
                        state    <= ahb_cache_pkg::ADDR_S;
                        addr_cnt <= '0;
                        data_cnt <= '0;
                    end
                end
                ahb_cache_pkg::ADDR_S: begin
                    // NONSEQ accepted
                    if (dn_rsp.hready) begin
                        state    <= ahb_cache_pkg::BEATS_S;
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                ahb_cache_pkg::BEATS_S: begin
                    // one data beat done, next SEQ accepted alongside
                    if (dn_rsp.hready) begin
                        data_cnt <= data_cnt + 1'b1;
                        if (!all_issued) begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                        if (last_beat) begin
                            state <= ahb_cache_pkg::DONE_S;
                        end
                    end
                end
                ahb_cache_pkg::DONE_S: begin
                    state <= ahb_cache_pkg::IDLE_S;
                end
                default: begin
                    state <= ahb_cache_pkg::IDLE_S;
                end
            endcase
        end
    end

    // burst base and critical word
    always_ff @(posedge upstream_intf) begin
        if (state == ahb_cache_pkg::IDLE_S && miss) begin
            line_base <= lookup.addr[31:`OFFSET_BITS + 2];
            start_off <= lookup.addr[2 +: `OFFSET_BITS];
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (state == ahb_cache_pkg::BEATS_S && dn_rsp.hready) begin
            line_buf[data_off] <= dn_rsp.hrdata;
        end
    end

    always_comb begin
        dn_req        = '0;
        dn_req.hburst = ahb_cache_pkg::WRAP4;
        dn_req.haddr  = {line_base, addr_off, 2'b00};
        case (state)
            ahb_cache_pkg::ADDR_S:  dn_req.htrans = ahb_cache_pkg::NONSEQ;
            ahb_cache_pkg::BEATS_S: begin
                dn_req.htrans = all_issued ? ahb_cache_pkg::IDLE : ahb_cache_pkg::SEQ;
            end
            default:                dn_req.htrans = ahb_cache_pkg::IDLE;
        endcase
    end

    // full line is in the buffer for the DONE_S cycle
    assign fill_line = line_buf;
    assign fill_done = (state == ahb_cache_pkg::DONE_S);

endmodule

//--- verilog.f
+incdir+hw
hw/ahb_cache_pkg.sv
hw/ahb_slave_capture.sv
hw/cache_tag_store.sv
hw/line_fill_master.sv
hw/ahb_read_cache.sv
bench/ahb_memory_model.sv
bench/ahb_read_cache_assertions.sv
bench/ahb_read_cache_tb.sv
